/* tests/rx_ppe_tests.txt */
# T name | W gap addr drop port | I cycles | F drains and reports | gap in cycles
# D ch gap id src dst vpri mc | E ch id port tc policer type drop | other fields hex
T reset_state
I 14
F
T latency
D 0 1 a5 03 05 6 0
E 0 a5 000 6 0c5 1 0
F
T table_lookup
W 1 05 0 023
W 1 11 1 1ff
W 1 2a 0 100
D 0 2 10 01 05 2 0
E 0 10 023 2 045 1 0
D 0 1 11 1f 11 7 0
E 0 11 1ff 7 7d1 1 1
D 1 1 12 0a 2a 0 0
E 1 12 100 0 2aa 1 0
D 1 1 13 00 3f 4 0
E 1 13 000 4 03f 1 0
F
T packet_type
D 0 1 20 02 05 1 1
E 0 20 023 1 085 0 0
D 0 1 21 02 05 1 0
E 0 21 023 1 085 1 0
D 1 0 22 04 11 3 1
E 1 22 1ff 3 111 0 1
D 1 1 23 04 00 5 0
E 1 23 000 5 100 1 0
F
T stream_both
D 0 1 30 01 05 0 0
E 0 30 023 0 045 1 0
D 1 0 40 1e 2a 7 1
E 1 40 100 7 7aa 0 0
D 0 1 31 01 11 1 1
E 0 31 1ff 1 051 0 1
D 1 0 41 1e 05 6 0
E 1 41 023 6 785 1 0
D 0 1 32 01 2a 2 0
E 0 32 100 2 06a 1 0
D 1 0 42 1e 11 5 1
E 1 42 1ff 5 791 0 1
F
T table_update
D 0 1 50 02 20 1 0
E 0 50 000 1 0a0 1 0
D 0 1 51 02 20 1 0
E 0 51 000 1 0a0 1 0
D 0 1 52 02 20 1 0
E 0 52 0aa 1 0a0 1 1
D 0 1 53 02 20 1 0
E 0 53 0aa 1 0a0 1 1
W 10 20 1 0aa
F

/* all.f */
source/rx_ppe_pkg.sv
source/ppe_delay_line.sv
source/ppe_port_table.sv
source/ppe_classifier.sv
source/rx_ppe_model.sv
tests/rx_ppe_model_assert.sv
tests/rx_ppe_model_tb.sv

/* Bender.yml */
package:
  name: rx_ppe_model

sources:
  - files:
      - source/rx_ppe_pkg.sv
      - source/ppe_delay_line.sv
      - source/ppe_port_table.sv
      - source/ppe_classifier.sv
      - source/rx_ppe_model.sv
  - target: test
    files:
      - tests/rx_ppe_model_assert.sv
      - tests/rx_ppe_model_tb.sv

/* tests/rx_ppe_model_tb.sv */
// ----------------------------------------
// rx ppe model testbench with file driven
// vectors and a scoreboard per channel
// ----------------------------------------

`default_nettype none

module rx_ppe_model_tb
  import rx_ppe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PIPE_DEPTH   = 12;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;

  logic            cclk;
  logic            rst;
  igr_ppe_head_t   head0;
  igr_ppe_head_t   head1;
  logic            cfg_we;
  dst_key_t        cfg_addr;
  port_entry_t     cfg_entry;
  ppe_igr_result_t result0;
  ppe_igr_result_t result1;

  int    seed;
  int    cycle = 0;
  int    errors = 0;
  int    checks = 0;
  int    test_errors = 0;
  int    test_checks = 0;
  int    tests_done = 0;
  int    watchdog_ns = 0;
  int    last_drive [2];
  string test_name = "none";
  string lines [$];

  // expected results and the cycle each one is due
  ppe_igr_result_t exp_q0 [$];
  ppe_igr_result_t exp_q1 [$];
  int              due_q0 [$];
  int              due_q1 [$];

  rx_ppe_model #(
    .PIPE_DEPTH (PIPE_DEPTH)
  ) dut0 (
    .cclk      (cclk),
    .rst       (rst),
    .head0     (head0),
    .head1     (head1),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_entry (cfg_entry),
    .result0   (result0),
    .result1   (result1)
  );

  initial begin
    cclk = 1'b0;
    forever #(CLK_PERIOD / 2) cclk = ~cclk;
  end

  // counts rising edges and is read only on falling edges
  always @(posedge cclk) begin
    cycle <= cycle + 1;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // idle slot with random fields and valid low
  function automatic igr_ppe_head_t idle_head();
    logic [31:0]   r;
    igr_ppe_head_t h;
    r = $random(seed);
    h = r[$bits(igr_ppe_head_t)-1:0];
    h.valid = 1'b0;
    return h;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // one clock then idle filler on every input
  task automatic step();
    logic [31:0] r;
    @(posedge cclk);
    @(negedge cclk);
    r = $random(seed);
    head0     <= idle_head();
    head1     <= idle_head();
    cfg_we    <= 1'b0;
    cfg_addr  <= r[5:0];
    cfg_entry <= r[15:6];
  endtask

  task automatic compare_result(input int ch, input ppe_igr_result_t got,
                                input ppe_igr_result_t exp, input int due);
    string tag;
    tag = $sformatf("ch%0d id %02h", ch, exp.id);
    check_value(cycle, due, {tag, " arrival cycle"});
    check_value(got.id, exp.id, {tag, " id"});
    check_value(got.port, exp.port, {tag, " port"});
    check_value(got.tc, exp.tc, {tag, " tc"});
    check_value(got.policer_idx, exp.policer_idx, {tag, " policer_idx"});
    check_value(got.pkt_type, exp.pkt_type, {tag, " pkt_type"});
    check_value(got.tx_drop, exp.tx_drop, {tag, " tx_drop"});
  endtask

  task automatic unexpected(input int ch, input ppe_igr_result_t got);
    errors++;
    test_errors++;
    $display("unexpected result on channel %0d (id %02h) at %0t ns, none was due",
             ch, got.id, $time);
  endtask

  // malformed or unknown line in the test file
  task automatic bad_line(input string line);
    errors++;
    test_errors++;
    $display("test file line not understood: %s", line);
  endtask

  // ----------------------------------------
  // scoreboard
  // ----------------------------------------

  always @(negedge cclk) begin
    if (!rst && result0.valid) begin
      if (exp_q0.size() == 0) begin
        unexpected(0, result0);
      end else begin
        compare_result(0, result0, exp_q0.pop_front(), due_q0.pop_front());
      end
    end
    if (!rst && result1.valid) begin
      if (exp_q1.size() == 0) begin
        unexpected(1, result1);
      end else begin
        compare_result(1, result1, exp_q1.pop_front(), due_q1.pop_front());
      end
    end
  end

  // ----------------------------------------
  // test file
  // ----------------------------------------

  task automatic load_tests(output bit ok);
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("tests/rx_ppe_tests.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        cnt = $fgets(line, fd);
        // skip comments and blank lines
        if (cnt > 1 && line.getc(0) != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  // stimulus cycles the file asks for including drains
  function automatic int count_cycles();
    int n;
    int ch;
    int gap;
    int total;
    total = RESET_CYCLES;
    foreach (lines[i]) begin
      n = 0;
      gap = 0;
      case (lines[i].getc(0))
        "D": n = $sscanf(lines[i], "D %d %d", ch, gap);
        "W": n = $sscanf(lines[i], "W %d", gap);
        "I": n = $sscanf(lines[i], "I %d", gap);
        "F": total += PIPE_DEPTH + 2;
        default: gap = 0;
      endcase
      // a line that did not parse adds no gap
      if (n > 0) begin
        total += gap;
      end
    end
    return total;
  endfunction

  task automatic run_tests();
    int              n;
    int              ch;
    int              gap;
    logic [31:0]     f [6];
    igr_ppe_head_t   h;
    ppe_igr_result_t r;
    port_entry_t     pe;
    foreach (lines[i]) begin
      case (lines[i].getc(0))
        "T": begin
          n = $sscanf(lines[i], "T %s", test_name);
          test_checks = 0;
          test_errors = 0;
          if (n != 1) begin
            bad_line(lines[i]);
          end
        end
        "W": begin
          n = $sscanf(lines[i], "W %d %h %h %h", gap, f[0], f[1], f[2]);
          if (n != 4) begin
            bad_line(lines[i]);
          end
          repeat (gap) step();
          pe.drop = f[1][0];
          pe.port = f[2][8:0];
          cfg_we    <= 1'b1;
          cfg_addr  <= f[0][5:0];
          cfg_entry <= pe;
        end
        "D": begin
          n = $sscanf(lines[i], "D %d %d %h %h %h %h %h", ch, gap, f[0], f[1], f[2],
                      f[3], f[4]);
          if (n != 7) begin
            bad_line(lines[i]);
          end
          repeat (gap) step();
          h.valid    = 1'b1;
          h.id       = f[0][7:0];
          h.src_port = f[1][4:0];
          h.dst_key  = f[2][5:0];
          h.vpri     = f[3][2:0];
          h.mc       = f[4][0];
          if (ch == 0) begin
            head0 <= h;
          end else begin
            head1 <= h;
          end
          last_drive[ch] = cycle;
        end
        "E": begin
          n = $sscanf(lines[i], "E %d %h %h %h %h %h %h", ch, f[0], f[1], f[2], f[3],
                      f[4], f[5]);
          if (n != 7) begin
            bad_line(lines[i]);
          end
          r             = '0;
          r.valid       = 1'b1;
          r.id          = f[0][7:0];
          r.port        = f[1][8:0];
          r.tc          = f[2][3:0];
          r.policer_idx = f[3][10:0];
          r.pkt_type    = pkt_type_t'(f[4][3:0]);
          r.tx_drop     = f[5][0];
          // seen on the falling edge PIPE_DEPTH+1 edges after sampling
          if (ch == 0) begin
            exp_q0.push_back(r);
            due_q0.push_back(last_drive[0] + PIPE_DEPTH + 1);
          end else begin
            exp_q1.push_back(r);
            due_q1.push_back(last_drive[1] + PIPE_DEPTH + 1);
          end
        end
        "I": begin
          n = $sscanf(lines[i], "I %d", gap);
          if (n != 1) begin
            bad_line(lines[i]);
          end
          repeat (gap) begin
            step();
            check_value(result0.valid, 1'b0, "ch0 valid while idle");
            check_value(result1.valid, 1'b0, "ch1 valid while idle");
          end
        end
        "F": begin
          step();
          while (exp_q0.size() != 0 || exp_q1.size() != 0) step();
          tests_done++;
          $display("[%0t ns] %s: %0d checks, %0d errors", $time, test_name,
                   test_checks, test_errors);
        end
        default: begin
          bad_line(lines[i]);
        end
      endcase
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    bit ok;
    seed      = 10;
    rst       = 1'b1;
    head0     = '0;
    head1     = '0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_entry = '0;
    load_tests(ok);
    if (!ok) begin
      $display("could not open tests/rx_ppe_tests.txt, no test was run");
      $display("test failed");
      $finish;
    end else begin
      watchdog_ns = (count_cycles() + PIPE_DEPTH + 50) * CLK_PERIOD;
      repeat (RESET_CYCLES) @(posedge cclk);
      @(negedge cclk);
      rst <= 1'b0;
      run_tests();
      $display("summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
      if (errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

  // watchdog armed once the file length is known
  initial begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("watchdog ran out after %0d ns, results still missing", watchdog_ns);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/rx_ppe_model_assert.sv */
// ----------------------------------------
// rx ppe model checks: quiet after reset,
// fixed latency, clean idle results
// ----------------------------------------

`default_nettype none

module rx_ppe_model_assert
  import rx_ppe_pkg::*;
#(
  parameter int PIPE_DEPTH = 160
) (
  input logic            cclk,
  input logic            rst,
  input igr_ppe_head_t   head0,
  input igr_ppe_head_t   head1,
  input ppe_igr_result_t result0,
  input ppe_igr_result_t result1
);

  timeunit 1ns;
  timeprecision 1ps;

  // results are known once a reset edge was seen
  logic seen_rst = 1'b0;
  int   since_rst = 0;
  logic quiet;

  always @(posedge cclk) begin
    if (rst) begin
      seen_rst  <= 1'b1;
      since_rst <= 0;
    end else if (since_rst < PIPE_DEPTH + 1) begin
      since_rst <= since_rst + 1;
    end
  end

  // window where nothing can have reached the result yet
  assign quiet = seen_rst && (rst || since_rst < PIPE_DEPTH + 1);

  a_quiet: assert property (@(posedge cclk) quiet |-> !result0.valid && !result1.valid)
    else $error("result valid during reset or before the pipeline could fill");

  // every result needs its descriptor PIPE_DEPTH+1 edges back
  a_lat0: assert property (@(posedge cclk) disable iff (rst)
    result0.valid |-> $past(head0.valid, PIPE_DEPTH + 1))
    else $error("channel 0 result without a matching descriptor");

  a_lat1: assert property (@(posedge cclk) disable iff (rst)
    result1.valid |-> $past(head1.valid, PIPE_DEPTH + 1))
    else $error("channel 1 result without a matching descriptor");

  a_zero0: assert property (@(posedge cclk) seen_rst && !result0.valid |-> result0 == '0)
    else $error("channel 0 idle result not all zero");

  a_zero1: assert property (@(posedge cclk) seen_rst && !result1.valid |-> result1 == '0)
    else $error("channel 1 idle result not all zero");

endmodule

bind rx_ppe_model rx_ppe_model_assert #(
  .PIPE_DEPTH (PIPE_DEPTH)
) checks0 (
  .cclk    (cclk),
  .rst     (rst),
  .head0   (head0),
  .head1   (head1),
  .result0 (result0),
  .result1 (result1)
);

`default_nettype wire

/* source/rx_ppe_model.sv */
// ----------------------------------------
// rx ppe model: two channel PPE stand-in,
// fixed latency plus port table classify
// ----------------------------------------

`default_nettype none

module rx_ppe_model
  import rx_ppe_pkg::*;
#(
  parameter int PIPE_DEPTH = 160
) (
  input  logic            cclk,
  input  logic            rst,
  // descriptors from ingress
  input  igr_ppe_head_t   head0,
  input  igr_ppe_head_t   head1,
  // port table config strobe
  input  logic            cfg_we,
  input  dst_key_t        cfg_addr,
  input  port_entry_t     cfg_entry,
  // results back to ingress
  output ppe_igr_result_t result0,
  output ppe_igr_result_t result1
);

  // oldest stage of each line
  igr_ppe_head_t delayed0;
  igr_ppe_head_t delayed1;

  // table entries for the delayed keys
  port_entry_t   entry0;
  port_entry_t   entry1;

  // ----------------------------------------
  // latency lines
  // ----------------------------------------

  ppe_delay_line #(
    .PIPE_DEPTH (PIPE_DEPTH)
  ) line0 (
    .cclk     (cclk),
    .rst      (rst),
    .head_in  (head0),
    .head_out (delayed0)
  );

  ppe_delay_line #(
    .PIPE_DEPTH (PIPE_DEPTH)
  ) line1 (
    .cclk     (cclk),
    .rst      (rst),
    .head_in  (head1),
    .head_out (delayed1)
  );

  // ----------------------------------------
  // shared table and classifiers
  // ----------------------------------------

  ppe_port_table ports0 (
    .cclk    (cclk),
    .rst     (rst),
    .we      (cfg_we),
    .waddr   (cfg_addr),
    .wentry  (cfg_entry),
    .raddr0  (delayed0.dst_key),
    .raddr1  (delayed1.dst_key),
    .rentry0 (entry0),
    .rentry1 (entry1)
  );

  ppe_classifier cls0 (
    .cclk   (cclk),
    .rst    (rst),
    .head   (delayed0),
    .entry  (entry0),
    .result (result0)
  );

  ppe_classifier cls1 (
    .cclk   (cclk),
    .rst    (rst),
    .head   (delayed1),
    .entry  (entry1),
    .result (result1)
  );

endmodule

`default_nettype wire

/* source/ppe_classifier.sv */
// ----------------------------------------
// ppe classifier: registered stage that
// builds the metadata result
// ----------------------------------------

`default_nettype none

module ppe_classifier
  import rx_ppe_pkg::*;
(
  input  logic            cclk,
  input  logic            rst,
  // delayed descriptor and its table entry
  input  igr_ppe_head_t   head,
  input  port_entry_t     entry,
  output ppe_igr_result_t result
);

  // ----------------------------------------
  // next result
  // ----------------------------------------

  ppe_igr_result_t result_d;
  tc_t             tc_d;
  policer_idx_t    policer_d;
  pkt_type_t       pkt_type_d;

  // tc from priority, zero on top
  assign tc_d = {1'b0, head.vpri};

  // policer index from source port and key
  assign policer_d = {head.src_port, head.dst_key};

  // mc flag picks the packet type
  assign pkt_type_d = head.mc ? MC : UC;

  always_comb begin
    // idle slot gives an all-zero result
    result_d = '0;
    if (head.valid) begin
      result_d.valid       = 1'b1;
      result_d.id          = head.id;
      // port and drop from the table
      result_d.port        = entry.port;
      result_d.tx_drop     = entry.drop;
      result_d.tc          = tc_d;
      result_d.policer_idx = policer_d;
      result_d.pkt_type    = pkt_type_d;
    end
  end

  // ----------------------------------------
  // output register
  // ----------------------------------------

  // one result per cycle, never held
  always_ff @(posedge cclk) begin
    if (rst) begin
      result <= '0;
    end else begin
      result <= result_d;
    end
  end

endmodule

`default_nettype wire

/* source/ppe_port_table.sv */
// ----------------------------------------
// ppe port table: 64 egress entries, one
// config write port, two lookup ports
// ----------------------------------------

`default_nettype none

module ppe_port_table
  import rx_ppe_pkg::*;
(
  input  logic        cclk,
  input  logic        rst,
  // config write
  input  logic        we,
  input  dst_key_t    waddr,
  input  port_entry_t wentry,
  // lookups, one per channel
  input  dst_key_t    raddr0,
  input  dst_key_t    raddr1,
  output port_entry_t rentry0,
  output port_entry_t rentry1
);

  // one entry per dst_key value
  localparam int TABLE_DEPTH = 1 << $bits(dst_key_t);

  // ----------------------------------------
  // entry storage
  // ----------------------------------------

  port_entry_t [TABLE_DEPTH-1:0] entries;

  always_ff @(posedge cclk) begin
    if (rst) begin
      // port 0, no drop everywhere
      entries <= '0;
    end else if (we) begin
      entries[waddr] <= wentry;
    end
  end

  // ----------------------------------------
  // lookups
  // ----------------------------------------

  // combinational reads
  // a write shows up from the next cycle
  // both channels share the same table
  assign rentry0 = entries[raddr0];
  assign rentry1 = entries[raddr1];

endmodule

`default_nettype wire

/* source/ppe_delay_line.sv */
// ----------------------------------------
// ppe delay line: shift pipeline that
// mimics the PPE latency
// ----------------------------------------

`default_nettype none

module ppe_delay_line
  import rx_ppe_pkg::*;
#(
  parameter int PIPE_DEPTH = 160
) (
  input  logic          cclk,
  input  logic          rst,
  input  igr_ppe_head_t head_in,
  output igr_ppe_head_t head_out
);

  // ----------------------------------------
  // stage storage
  // ----------------------------------------

  // stage 0 takes the new descriptor
  // stage PIPE_DEPTH-1 holds the oldest
  igr_ppe_head_t [PIPE_DEPTH-1:0] stages;

  always_ff @(posedge cclk) begin
    if (rst) begin
      // clear all, no stale valid after reset
      stages <= '0;
    end else begin
      stages[0] <= head_in;
      // shift one stage per clock
      // loop is empty when depth is 1
      for (int i = 1; i < PIPE_DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  // ----------------------------------------
  // output
  // ----------------------------------------

  // oldest stage goes to the classifier
  assign head_out = stages[PIPE_DEPTH-1];

endmodule

`default_nettype wire

/* source/rx_ppe_pkg.sv */
// ----------------------------------------
// rx ppe package: descriptor and result types
// shared by the PPE stand-in model
// ----------------------------------------

`default_nettype none

package rx_ppe_pkg;

  // ----------------------------------------
  // width types
  // ----------------------------------------

  // header segment packet id
  typedef logic [7:0]  pkt_id_t;
  // egress port number
  typedef logic [8:0]  port_t;
  // receiving port
  typedef logic [4:0]  src_port_t;
  // port table index carried in the header
  typedef logic [5:0]  dst_key_t;
  // header priority
  typedef logic [2:0]  vpri_t;
  // egress traffic class
  typedef logic [3:0]  tc_t;
  // policer index, src_port then dst_key
  typedef logic [10:0] policer_idx_t;

  // packet type, codes match the full metadata encoding
  typedef enum logic [3:0] {
    MC = 4'h0,
    UC = 4'h1
  } pkt_type_t;

  // ----------------------------------------
  // structs
  // ----------------------------------------

  // one port table entry
  typedef struct packed {
    logic  drop;
    port_t port;
  } port_entry_t;

  // header descriptor from ingress
  typedef struct packed {
    logic      valid;
    pkt_id_t   id;
    src_port_t src_port;
    dst_key_t  dst_key;
    vpri_t     vpri;
    // multicast flag
    logic      mc;
  } igr_ppe_head_t;

  // classified result back to ingress
  typedef struct packed {
    logic         valid;
    pkt_id_t      id;
    port_t        port;
    tc_t          tc;
    policer_idx_t policer_idx;
    pkt_type_t    pkt_type;
    // egress should drop the frame
    logic         tx_drop;
  } ppe_igr_result_t;

endpackage

`default_nettype wire
